// File: hw/front_params.svh
/*
  Widths, queue depths and reset pc of the instruction front end
*/
`ifndef FRONT_PARAMS_SVH
`define FRONT_PARAMS_SVH

// Instruction word, pc and immediate width
`define FRONT_XLEN 32

// AXI read data width, two instructions per beat
`define FRONT_BEAT_W 64

// Fetched word queue between fetch and decode
`define FRONT_FQ_DEPTH 4

// Decoded instruction queue in front of the decode port
`define FRONT_DQ_DEPTH 2

// First fetch address out of reset
`define FRONT_RESET_PC 32'h0000_1000

`endif

// File: hw/front_pkg.sv
/*
  Types shared by the fetch master, the queues and the decoder
*/
`include "front_params.svh"
`default_nettype none

package front_pkg;

  // Good read response
  localparam logic [1:0] axi_resp_okay = 2'b00;

  typedef enum logic [3:0] {
    OP_ALU     = 4'd0,
    OP_ALU_IMM = 4'd1,
    OP_LOAD    = 4'd2,
    OP_STORE   = 4'd3,
    OP_BRANCH  = 4'd4,
    OP_JAL     = 4'd5,
    OP_JALR    = 4'd6,
    OP_LUI     = 4'd7,
    OP_AUIPC   = 4'd8,
    OP_SYSTEM  = 4'd9,
    OP_ILLEGAL = 4'd10
  } op_class_t;

  // One instruction word as fetched
  typedef struct packed {
    logic [`FRONT_XLEN-1:0] pc;
    logic [`FRONT_XLEN-1:0] instr;
    logic                   fault;
  } fetch_pkt_t;

  // Decoded instruction handed to the back end
  typedef struct packed {
    logic [`FRONT_XLEN-1:0] pc;
    op_class_t              op;
    logic [2:0]             funct3;
    logic [4:0]             rd;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [`FRONT_XLEN-1:0] imm;
    logic                   rd_en;
    logic                   illegal;
    logic                   fault;
  } dec_pkt_t;

endpackage : front_pkg

`default_nettype wire

// File: hw/axi_fetch_master.sv
/*
  Fetch master: issues single-beat AXI4 reads from the pc, drops reads
  overtaken by a redirect and splits each 64-bit beat into instruction words
*/
`timescale 1ns/1ps
`include "front_params.svh"
`default_nettype none

module axi_fetch_master (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     redirect_valid,
  input  logic [`FRONT_XLEN-1:0]   redirect_pc,
  output logic                     axi_arid,
  output logic [`FRONT_XLEN-1:0]   axi_araddr,
  output logic [7:0]               axi_arlen,
  output logic [2:0]               axi_arsize,
  output logic [1:0]               axi_arburst,
  output logic                     axi_arvalid,
  input  logic                     axi_arready,
  input  logic                     axi_rid,
  input  logic [`FRONT_BEAT_W-1:0] axi_rdata,
  input  logic [1:0]               axi_rresp,
  input  logic                     axi_rlast,
  input  logic                     axi_rvalid,
  output logic                     axi_rready,
  output logic                     fq_in_valid,
  output front_pkg::fetch_pkt_t    fq_in_data,
  input  logic                     fq_in_ready
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    ADDRESS = 2'b01,
    DATA    = 2'b10
  } rd_state_t;

  rd_state_t                state;
  // pc of the next word to push, also the source of the next fetch
  logic [`FRONT_XLEN-1:0]   pc;
  logic [`FRONT_XLEN-1:0]   ar_addr;
  logic                     drop;
  logic [`FRONT_BEAT_W-1:0] beat_data;
  logic                     beat_fault;
  logic                     beat_valid;
  logic                     ar_fire;
  logic                     r_fire;
  logic                     push;

  assign ar_fire = axi_arvalid && axi_arready;
  assign r_fire  = axi_rvalid && axi_rready;
  assign push    = fq_in_valid && fq_in_ready;

  // One beat, INCR, eight bytes, fixed id
  assign axi_arid    = 1'b0;
  assign axi_araddr  = ar_addr;
  assign axi_arlen   = 8'd0;
  assign axi_arsize  = 3'd3;
  assign axi_arburst = 2'b01;
  assign axi_arvalid = (state == ADDRESS);
  assign axi_rready  = (state == DATA) && !beat_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      drop  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Next read waits until the last word of the beat is pushed
          if (!beat_valid && !redirect_valid) begin
            state <= ADDRESS;
          end
        end
        ADDRESS: begin
          if (ar_fire) begin
            state <= DATA;
          end
          if (redirect_valid) begin
            drop <= 1'b1;
          end
        end
        DATA: begin
          if (r_fire) begin
            state <= IDLE;
            drop  <= 1'b0;
          end else if (redirect_valid) begin
            drop <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      ar_addr <= {pc[`FRONT_XLEN-1:3], 3'b000};
    end
    if (r_fire) begin
      beat_data <= axi_rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= `FRONT_RESET_PC;
      beat_valid <= 1'b0;
      beat_fault <= 1'b0;
    end else if (redirect_valid) begin
      pc         <= {redirect_pc[`FRONT_XLEN-1:2], 2'b00};
      beat_valid <= 1'b0;
    end else if (r_fire && !drop) begin
      beat_valid <= 1'b1;
      beat_fault <= (axi_rresp != front_pkg::axi_resp_okay);
    end else if (push) begin
      pc <= pc + `FRONT_XLEN'(4);
      // Upper word ends the beat
      if (pc[2]) begin
        beat_valid <= 1'b0;
      end
    end
  end

  always_comb begin
    fq_in_valid       = beat_valid;
    fq_in_data.pc     = pc;
    fq_in_data.instr  = pc[2] ? beat_data[`FRONT_BEAT_W-1:`FRONT_XLEN]
                              : beat_data[`FRONT_XLEN-1:0];
    fq_in_data.fault  = beat_fault;
  end

  // Address holds while the slave stalls the request
  ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr));

  // Every beat closes the single-beat burst on the id we issued
  r_last_a: assert property (@(posedge clk) disable iff (!rst_n)
    r_fire |-> axi_rlast && (axi_rid == axi_arid));

endmodule : axi_fetch_master

`default_nettype wire

// File: hw/instr_queue.sv
/*
  Synchronous FIFO for any packed payload, emptied by flush
*/
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // No pass-through when full
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Count never passes the number of slots
  overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH));

  // Empty queue keeps its pointers together
  underflow_a: assert property (@(posedge clk) disable iff (!rst_n)
    (count == '0) |-> (wr_ptr == rd_ptr));

endmodule : instr_queue

`default_nettype wire

// File: hw/id_stage.sv
/*
  RV32I decoder: operation class, register fields, immediate and
  illegal/fault flags, combinational between the two queues
*/
`timescale 1ns/1ps
`include "front_params.svh"
`default_nettype none

module id_stage (
  input  logic                  in_valid,
  output logic                  in_ready,
  input  front_pkg::fetch_pkt_t in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output front_pkg::dec_pkt_t   out_data
);

  logic [`FRONT_XLEN-1:0] instr;
  front_pkg::op_class_t   op;
  logic [`FRONT_XLEN-1:0] imm_i;
  logic [`FRONT_XLEN-1:0] imm_s;
  logic [`FRONT_XLEN-1:0] imm_b;
  logic [`FRONT_XLEN-1:0] imm_u;
  logic [`FRONT_XLEN-1:0] imm_j;

  assign instr     = in_data.instr;
  assign in_ready  = out_ready;
  assign out_valid = in_valid;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Full 7-bit match, so bits 1:0 other than 2'b11 fall to illegal
  always_comb begin
    case (instr[6:0])
      7'b0110011: op = front_pkg::OP_ALU;
      7'b0010011: op = front_pkg::OP_ALU_IMM;
      7'b0000011: op = front_pkg::OP_LOAD;
      7'b0100011: op = front_pkg::OP_STORE;
      7'b1100011: op = front_pkg::OP_BRANCH;
      7'b1101111: op = front_pkg::OP_JAL;
      7'b1100111: op = front_pkg::OP_JALR;
      7'b0110111: op = front_pkg::OP_LUI;
      7'b0010111: op = front_pkg::OP_AUIPC;
      7'b1110011: op = front_pkg::OP_SYSTEM;
      default:    op = front_pkg::OP_ILLEGAL;
    endcase
  end

  always_comb begin
    out_data.pc     = in_data.pc;
    out_data.op     = op;
    out_data.funct3 = instr[14:12];
    out_data.rd     = instr[11:7];
    out_data.rs1    = instr[19:15];
    out_data.rs2    = instr[24:20];

    case (op)
      front_pkg::OP_ALU_IMM,
      front_pkg::OP_LOAD,
      front_pkg::OP_JALR:   out_data.imm = imm_i;
      front_pkg::OP_STORE:  out_data.imm = imm_s;
      front_pkg::OP_BRANCH: out_data.imm = imm_b;
      front_pkg::OP_LUI,
      front_pkg::OP_AUIPC:  out_data.imm = imm_u;
      front_pkg::OP_JAL:    out_data.imm = imm_j;
      default:              out_data.imm = '0;
    endcase

    // Writes to x0 never enable the destination
    case (op)
      front_pkg::OP_ALU,
      front_pkg::OP_ALU_IMM,
      front_pkg::OP_LOAD,
      front_pkg::OP_JAL,
      front_pkg::OP_JALR,
      front_pkg::OP_LUI,
      front_pkg::OP_AUIPC: out_data.rd_en = (instr[11:7] != 5'd0);
      default:             out_data.rd_en = 1'b0;
    endcase

    // A bus error makes the word unusable as well
    out_data.illegal = (op == front_pkg::OP_ILLEGAL) || in_data.fault;
    out_data.fault   = in_data.fault;
  end

endmodule : id_stage

`default_nettype wire

// File: hw/riscv_front.sv
/*
  Instruction front end: AXI4 fetch master, fetch queue, RV32I decoder
  and decoded queue, with a redirect that flushes the whole path
*/
`timescale 1ns/1ps
`include "front_params.svh"
`default_nettype none

module riscv_front (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     redirect_valid,
  input  logic [`FRONT_XLEN-1:0]   redirect_pc,

  // AR channel
  output logic                     axi_arid,
  output logic [`FRONT_XLEN-1:0]   axi_araddr,
  output logic [7:0]               axi_arlen,
  output logic [2:0]               axi_arsize,
  output logic [1:0]               axi_arburst,
  output logic                     axi_arvalid,
  input  logic                     axi_arready,

  // R channel
  input  logic                     axi_rid,
  input  logic [`FRONT_BEAT_W-1:0] axi_rdata,
  input  logic [1:0]               axi_rresp,
  input  logic                     axi_rlast,
  input  logic                     axi_rvalid,
  output logic                     axi_rready,

  // Decode port
  output logic                     dec_valid,
  input  logic                     dec_ready,
  output logic [`FRONT_XLEN-1:0]   dec_pc,
  output front_pkg::op_class_t     dec_op,
  output logic [2:0]               dec_funct3,
  output logic [4:0]               dec_rd,
  output logic [4:0]               dec_rs1,
  output logic [4:0]               dec_rs2,
  output logic [`FRONT_XLEN-1:0]   dec_imm,
  output logic                     dec_rd_en,
  output logic                     dec_illegal,
  output logic                     dec_fault
);

  logic                  fq_in_valid;
  logic                  fq_in_ready;
  front_pkg::fetch_pkt_t fq_in_data;
  logic                  fq_out_valid;
  logic                  fq_out_ready;
  front_pkg::fetch_pkt_t fq_out_data;
  logic                  dq_in_valid;
  logic                  dq_in_ready;
  front_pkg::dec_pkt_t   dq_in_data;
  front_pkg::dec_pkt_t   dq_out_data;

  axi_fetch_master fetch_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .axi_arid      (axi_arid),
    .axi_araddr    (axi_araddr),
    .axi_arlen     (axi_arlen),
    .axi_arsize    (axi_arsize),
    .axi_arburst   (axi_arburst),
    .axi_arvalid   (axi_arvalid),
    .axi_arready   (axi_arready),
    .axi_rid       (axi_rid),
    .axi_rdata     (axi_rdata),
    .axi_rresp     (axi_rresp),
    .axi_rlast     (axi_rlast),
    .axi_rvalid    (axi_rvalid),
    .axi_rready    (axi_rready),
    .fq_in_valid   (fq_in_valid),
    .fq_in_data    (fq_in_data),
    .fq_in_ready   (fq_in_ready)
  );

  instr_queue #(
    .payload_t(front_pkg::fetch_pkt_t),
    .DEPTH    (`FRONT_FQ_DEPTH)
  ) fetch_q_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (redirect_valid),
    .in_valid (fq_in_valid),
    .in_ready (fq_in_ready),
    .in_data  (fq_in_data),
    .out_valid(fq_out_valid),
    .out_ready(fq_out_ready),
    .out_data (fq_out_data)
  );

  id_stage id_i (
    .in_valid (fq_out_valid),
    .in_ready (fq_out_ready),
    .in_data  (fq_out_data),
    .out_valid(dq_in_valid),
    .out_ready(dq_in_ready),
    .out_data (dq_in_data)
  );

  instr_queue #(
    .payload_t(front_pkg::dec_pkt_t),
    .DEPTH    (`FRONT_DQ_DEPTH)
  ) dec_q_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (redirect_valid),
    .in_valid (dq_in_valid),
    .in_ready (dq_in_ready),
    .in_data  (dq_in_data),
    .out_valid(dec_valid),
    .out_ready(dec_ready),
    .out_data (dq_out_data)
  );

  // Decoded packet onto the loose port fields
  assign dec_pc      = dq_out_data.pc;
  assign dec_op      = dq_out_data.op;
  assign dec_funct3  = dq_out_data.funct3;
  assign dec_rd      = dq_out_data.rd;
  assign dec_rs1     = dq_out_data.rs1;
  assign dec_rs2     = dq_out_data.rs2;
  assign dec_imm     = dq_out_data.imm;
  assign dec_rd_en   = dq_out_data.rd_en;
  assign dec_illegal = dq_out_data.illegal;
  assign dec_fault   = dq_out_data.fault;

endmodule : riscv_front

`default_nettype wire

// File: test/axi_rom_model.sv
/*
  AXI4 read slave for the fetch testbench: seeded random instruction table,
  random ready/valid delays and SLVERR over an address window
*/
`timescale 1ns/1ps
`include "front_params.svh"
`default_nettype none

module axi_rom_model #(
  parameter int          WORDS  = 4096,
  parameter logic [31:0] ERR_LO = 32'h0000_1800,
  parameter logic [31:0] ERR_HI = 32'h0000_187F
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     axi_arid,
  input  logic [`FRONT_XLEN-1:0]   axi_araddr,
  input  logic                     axi_arvalid,
  output logic                     axi_arready,
  output logic                     axi_rid,
  output logic [`FRONT_BEAT_W-1:0] axi_rdata,
  output logic [1:0]               axi_rresp,
  output logic                     axi_rlast,
  output logic                     axi_rvalid,
  input  logic                     axi_rready
);

  localparam int         IDX_W  = $clog2(WORDS);
  localparam logic [1:0] SLVERR = 2'b10;

  logic [31:0]            rom [WORDS];
  integer                 seed = 19229;
  logic                   busy;
  logic                   id;
  logic [`FRONT_XLEN-1:0] addr;
  int                     delay;

  function automatic logic [6:0] rv32i_opcode(input int unsigned sel);
    case (sel)
      0:       return 7'b0110011;
      1:       return 7'b0010011;
      2:       return 7'b0000011;
      3:       return 7'b0100011;
      4:       return 7'b1100011;
      5:       return 7'b1101111;
      6:       return 7'b1100111;
      7:       return 7'b0110111;
      8:       return 7'b0010111;
      default: return 7'b1110011;
    endcase
  endfunction

  // About one word in ten gets a real opcode, the rest stay raw
  initial begin
    logic [31:0] word;
    for (int i = 0; i < WORDS; i++) begin
      word = $random(seed);
      if (($unsigned($random(seed)) % 10) == 0) begin
        word[6:0] = rv32i_opcode($unsigned($random(seed)) % 10);
      end
      rom[i] = word;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      axi_arready <= 1'b0;
      axi_rvalid  <= 1'b0;
      axi_rid     <= 1'b0;
      axi_rdata   <= '0;
      axi_rresp   <= front_pkg::axi_resp_okay;
      axi_rlast   <= 1'b0;
      busy        <= 1'b0;
      id          <= 1'b0;
      addr        <= '0;
      delay       <= 0;
    end else if (!busy) begin
      if (axi_arvalid && axi_arready) begin
        busy        <= 1'b1;
        axi_arready <= 1'b0;
        id          <= axi_arid;
        addr        <= axi_araddr;
        delay       <= $unsigned($random(seed)) % 6;
      end else begin
        axi_arready <= (($random(seed) & 3) != 0);
      end
    end else if (!axi_rvalid) begin
      // Beat appears after the random latency with the low word at the lower address
      if (delay == 0) begin
        axi_rvalid <= 1'b1;
        axi_rlast  <= 1'b1;
        axi_rid    <= id;
        axi_rdata  <= {rom[{addr[IDX_W+1:3], 1'b1}], rom[{addr[IDX_W+1:3], 1'b0}]};
        axi_rresp  <= ((addr >= ERR_LO) && (addr <= ERR_HI)) ? SLVERR
                                                             : front_pkg::axi_resp_okay;
      end else begin
        delay <= delay - 1;
      end
    end else if (axi_rready) begin
      axi_rvalid <= 1'b0;
      axi_rlast  <= 1'b0;
      busy       <= 1'b0;
    end
  end

endmodule : axi_rom_model

`default_nettype wire

// File: test/tb_riscv_front.sv
/*
  Testbench for the instruction front end: random redirects, decode
  back-pressure and AXI delays checked against a pc-order reference model
*/
`timescale 1ns/1ps
`include "front_params.svh"
`default_nettype none

module tb_riscv_front;

  localparam int          IDX_W     = 12;
  localparam logic [31:0] ERR_LO    = 32'h0000_1800;
  localparam logic [31:0] ERR_HI    = 32'h0000_187F;
  localparam int          TIMEOUT   = 400;
  localparam int          NUM_INSTR = 2000;

  logic                     clk;
  logic                     rst_n;
  logic                     redirect_valid;
  logic [`FRONT_XLEN-1:0]   redirect_pc;
  logic                     axi_arid;
  logic [`FRONT_XLEN-1:0]   axi_araddr;
  logic [7:0]               axi_arlen;
  logic [2:0]               axi_arsize;
  logic [1:0]               axi_arburst;
  logic                     axi_arvalid;
  logic                     axi_arready;
  logic                     axi_rid;
  logic [`FRONT_BEAT_W-1:0] axi_rdata;
  logic [1:0]               axi_rresp;
  logic                     axi_rlast;
  logic                     axi_rvalid;
  logic                     axi_rready;
  logic                     dec_valid;
  logic                     dec_ready;
  logic [`FRONT_XLEN-1:0]   dec_pc;
  front_pkg::op_class_t     dec_op;
  logic [2:0]               dec_funct3;
  logic [4:0]               dec_rd;
  logic [4:0]               dec_rs1;
  logic [4:0]               dec_rs2;
  logic [`FRONT_XLEN-1:0]   dec_imm;
  logic                     dec_rd_en;
  logic                     dec_illegal;
  logic                     dec_fault;

  integer                 seed = 19229;
  // Pc of the next instruction expected on the decode port
  logic [`FRONT_XLEN-1:0] exp_pc;
  logic                   read_open;
  int                     checked;
  int                     redirects;
  int                     bit2_redirects;
  int                     inflight_redirects;
  int                     faults;

  riscv_front dut_i (.*);

  axi_rom_model #(
    .WORDS (1 << IDX_W),
    .ERR_LO(ERR_LO),
    .ERR_HI(ERR_HI)
  ) rom_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  // Immediates laid out per RV32I instruction format
  function automatic front_pkg::dec_pkt_t reference_decode(input logic [31:0] pc,
                                                           input logic [31:0] w);
    front_pkg::dec_pkt_t d;
    logic                writes;
    d.pc     = pc;
    d.funct3 = w[14:12];
    d.rd     = w[11:7];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.imm    = '0;
    d.op     = front_pkg::OP_ILLEGAL;
    d.fault  = (pc >= ERR_LO) && (pc <= ERR_HI);
    writes   = 1'b0;
    if (w[1:0] == 2'b11) begin
      case (w[6:2])
        5'b01100: begin
          d.op   = front_pkg::OP_ALU;
          writes = 1'b1;
        end
        5'b00100: begin
          d.op   = front_pkg::OP_ALU_IMM;
          d.imm  = $signed(w) >>> 20;
          writes = 1'b1;
        end
        5'b00000: begin
          d.op   = front_pkg::OP_LOAD;
          d.imm  = $signed(w) >>> 20;
          writes = 1'b1;
        end
        5'b01000: begin
          d.op  = front_pkg::OP_STORE;
          d.imm = {{21{w[31]}}, w[30:25], w[11:7]};
        end
        5'b11000: begin
          d.op  = front_pkg::OP_BRANCH;
          d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        5'b11011: begin
          d.op   = front_pkg::OP_JAL;
          d.imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
          writes = 1'b1;
        end
        5'b11001: begin
          d.op   = front_pkg::OP_JALR;
          d.imm  = $signed(w) >>> 20;
          writes = 1'b1;
        end
        5'b01101: begin
          d.op   = front_pkg::OP_LUI;
          d.imm  = w & 32'hFFFF_F000;
          writes = 1'b1;
        end
        5'b00101: begin
          d.op   = front_pkg::OP_AUIPC;
          d.imm  = w & 32'hFFFF_F000;
          writes = 1'b1;
        end
        5'b11100: d.op = front_pkg::OP_SYSTEM;
        default:  d.op = front_pkg::OP_ILLEGAL;
      endcase
    end
    d.rd_en   = writes && (w[11:7] != 5'd0);
    d.illegal = (d.op == front_pkg::OP_ILLEGAL) || d.fault;
    return d;
  endfunction

  // Sample what crossed this clock edge, then drive the next cycle
  task automatic step_cycle(output logic took);
    front_pkg::dec_pkt_t want;
    logic [31:0]         target;
    @(posedge clk);
    took = 1'b0;
    // Redirect lands between the AR and R handshakes of a read
    if (redirect_valid && read_open) begin
      inflight_redirects++;
    end
    if (axi_arvalid && axi_arready) begin
      check_value("axi_arid", 32'(axi_arid), 32'd0);
      check_value("axi_arlen", 32'(axi_arlen), 32'd0);
      check_value("axi_arsize", 32'(axi_arsize), 32'd3);
      check_value("axi_arburst", 32'(axi_arburst), 32'd1);
      check_value("axi_araddr[2:0]", 32'(axi_araddr[2:0]), 32'd0);
      read_open = 1'b1;
    end
    if (axi_rvalid && axi_rready) begin
      read_open = 1'b0;
    end
    if (dec_valid && dec_ready) begin
      want = reference_decode(exp_pc, rom_i.rom[exp_pc[IDX_W+1:2]]);
      check_value("dec_pc", dec_pc, want.pc);
      check_value("dec_op", 32'(dec_op), 32'(want.op));
      check_value("dec_funct3", 32'(dec_funct3), 32'(want.funct3));
      check_value("dec_rd", 32'(dec_rd), 32'(want.rd));
      check_value("dec_rs1", 32'(dec_rs1), 32'(want.rs1));
      check_value("dec_rs2", 32'(dec_rs2), 32'(want.rs2));
      check_value("dec_imm", dec_imm, want.imm);
      check_value("dec_rd_en", 32'(dec_rd_en), 32'(want.rd_en));
      check_value("dec_illegal", 32'(dec_illegal), 32'(want.illegal));
      check_value("dec_fault", 32'(dec_fault), 32'(want.fault));
      if (want.fault) begin
        faults++;
      end
      exp_pc  = exp_pc + 32'd4;
      checked++;
      took    = 1'b1;
    end
    if (redirect_valid) begin
      exp_pc = {redirect_pc[31:2], 2'b00};
      if (redirect_pc[2]) begin
        bit2_redirects++;
      end
    end
    dec_ready <= (($random(seed) & 3) != 0);
    if (!redirect_valid && (($random(seed) & 63) == 0)) begin
      redirects++;
      // Every eighth target is the upper word of the first SLVERR beat
      if (redirects % 8 == 0) begin
        target = ERR_LO | 32'h0000_0004;
      end else begin
        target = 32'h0000_1000 | ($random(seed) & 32'h0000_0FFF);
      end
      redirect_valid <= 1'b1;
      redirect_pc    <= target;
    end else begin
      redirect_valid <= 1'b0;
    end
  endtask

  initial begin
    logic took;
    int   cycles;
    rst_n              = 1'b0;
    redirect_valid     = 1'b0;
    redirect_pc        = '0;
    dec_ready          = 1'b0;
    exp_pc             = `FRONT_RESET_PC;
    read_open          = 1'b0;
    checked            = 0;
    redirects          = 0;
    bit2_redirects     = 0;
    inflight_redirects = 0;
    faults             = 0;
    repeat (16) @(posedge clk);
    check_value("dec_valid", 32'(dec_valid), 32'd0);
    check_value("axi_arvalid", 32'(axi_arvalid), 32'd0);
    check_value("axi_rready", 32'(axi_rready), 32'd0);
    rst_n <= 1'b1;

    while (checked < NUM_INSTR) begin
      cycles = 0;
      took   = 1'b0;
      while (!took) begin
        if (cycles == TIMEOUT) begin
          report_failure($sformatf("No decoded instruction within %0d cycles, expected pc 0x%h",
                                   TIMEOUT, exp_pc));
        end
        step_cycle(took);
        cycles++;
      end
    end

    if (bit2_redirects == 0 || inflight_redirects == 0 || faults == 0) begin
      report_failure($sformatf("Scenario not reached: %0d bit-2 redirects, %0d in-flight, %0d faults",
                               bit2_redirects, inflight_redirects, faults));
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule : tb_riscv_front

`default_nettype wire

// File: riscv_front.f
+incdir+hw
hw/front_pkg.sv
hw/axi_fetch_master.sv
hw/instr_queue.sv
hw/id_stage.sv
hw/riscv_front.sv
test/axi_rom_model.sv
test/tb_riscv_front.sv

// File: run_sim.sh
#!/bin/sh
# Build the front end testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_riscv_front \
  -f riscv_front.f \
  --Mdir obj_dir -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
run_status=$?
printf '%s\n' "$output"
if [ $run_status -ne 0 ]; then
  echo "Simulation binary exited with status $run_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
